//--- files.f
src/vga_pkg.sv
src/vga_sync_gen.sv
src/vga_scan_engine.sv
src/vga_frame_buffer.sv
src/vga_controller_top.sv
verification/tb_vga_controller.sv

//--- src/vga_controller_top.sv
/* VGA controller top, 640x480 from a frame buffer written over the local bus.
   Single clock for bus and pixels, so the clock must be the 25 MHz-class pixel clock. */
`timescale 1ns/1ns

module vga_controller_top import vga_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // Local bus
    input  logic      sel,      // Access strobe
    input  fb_addr_t  addr,     // Pixel address
    input  chan_we_t  we,       // Channel write enables
    input  bus_word_t qin,      // Write data
    output bus_word_t qout,     // Read data

    // Display
    output logic      hsync,    // Active low
    output logic      vsync,    // Active low
    output colour_t   rdata,
    output colour_t   gdata,
    output colour_t   bdata
);

    // Display read path between scan engine and memory
    fb_addr_t pix_addr;
    pixel_t   pix_data;

    // Raster timing and colour output
    vga_scan_engine scan_i (
        .clk      (clk),
        .rst      (rst),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .hsync    (hsync),
        .vsync    (vsync),
        .rdata    (rdata),
        .gdata    (gdata),
        .bdata    (bdata)
    );

    /* Bus side has full access, display side is read only.
       Both run on clk so no crossing logic is needed */
    vga_frame_buffer fb_i (
        .clk      (clk),
        .rst      (rst),
        .sel      (sel),
        .addr     (addr),
        .we       (we),
        .qin      (qin),
        .qout     (qout),
        .pix_addr (pix_addr),
        .pix_data (pix_data)
    );

endmodule

//--- src/vga_frame_buffer.sv
/* Dual-port pixel memory. Bus port reads and writes with per-channel masks, display port reads.
   Both ports have one clock of latency. Bus accesses at or above FB_DEPTH are dropped. */
`timescale 1ns/1ns

module vga_frame_buffer import vga_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      sel,        // Bus access strobe
    input  fb_addr_t  addr,       // Bus pixel address
    input  chan_we_t  we,         // Channel enables, zero means read
    input  bus_word_t qin,        // Write data, low 12 bits used
    output bus_word_t qout,       // Read data, upper bits zero
    input  fb_addr_t  pix_addr,   // Display read address
    output pixel_t    pix_data    // Display read data
);

    pixel_t mem [FB_DEPTH];       // One word per visible pixel

    logic   in_range;
    logic   bus_wr;
    logic   bus_rd;
    pixel_t wr_data;

    // Address decode
    assign in_range = (addr < fb_addr_t'(FB_DEPTH));
    assign bus_wr   = sel && (we != '0) && in_range;   // Out-of-range writes dropped
    assign bus_rd   = sel && (we == '0);
    assign wr_data  = qin[11:0];

    /* Bus write port. Each channel nibble has its own enable so a
       partial write leaves the other channels untouched */
    always_ff @(posedge clk) begin
        if (bus_wr) begin
            if (we[2]) begin
                mem[addr][11:8] <= wr_data[11:8];    // Red
            end
            if (we[1]) begin
                mem[addr][7:4]  <= wr_data[7:4];     // Green
            end
            if (we[0]) begin
                mem[addr][3:0]  <= wr_data[3:0];     // Blue
            end
        end
    end

    // Bus read, held until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            qout <= '0;
        end else if (bus_rd) begin
            if (in_range)
                qout <= bus_word_t'(mem[addr]);     // Zero extended
            else
                qout <= '0;
        end
    end

    // Display port, old data on a same-cycle write
    always_ff @(posedge clk) begin
        pix_data <= mem[pix_addr];
    end

endmodule

//--- src/vga_pkg.sv
/* Shared widths, types and 640x480 @ 60 Hz timing for the VGA controller.
   Pixels are packed as 4-bit R, G and B. Frame buffer holds one active frame only. */
package vga_pkg;

    // Local bus data width
    localparam int XLEN = 32;

    // Horizontal timing in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    // Sync pulse windows, start inclusive and end exclusive
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;      // 656
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;   // 752
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;      // 490
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;   // 492

    // One word per visible pixel
    localparam int FB_DEPTH = H_ACTIVE * V_ACTIVE;         // 307200

    // {red, green, blue}, 4 bits each
    typedef logic [11:0] pixel_t;

    // Single colour channel
    typedef logic [3:0] colour_t;

    // Enough for FB_DEPTH words
    typedef logic [18:0] fb_addr_t;

    // Raster counters, both count up to under 1024
    typedef logic [9:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // Bit 2 red, bit 1 green, bit 0 blue
    typedef logic [2:0] chan_we_t;

    // Bus data word
    typedef logic [XLEN-1:0] bus_word_t;

endpackage

//--- src/vga_scan_engine.sv
/* Scan-out: pixel addressing, two-stage pipeline and blanking of the colour outputs.
   Outputs lag the raster counters by two clocks. Frame buffer read latency must be one clock. */
`timescale 1ns/1ns

module vga_scan_engine import vga_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output fb_addr_t pix_addr,   // To frame buffer display port
    input  pixel_t   pix_data,   // Returned one clock after pix_addr
    output logic     hsync,
    output logic     vsync,
    output colour_t  rdata,
    output colour_t  gdata,
    output colour_t  bdata
);

    hcount_t  hcount;
    vcount_t  vcount;
    logic     raw_hsync;
    logic     raw_vsync;
    logic     active;
    logic     frame_end;
    fb_addr_t next_addr;         // Address of the next visible pixel
    logic     hsync_d1;
    logic     vsync_d1;
    logic     active_d1;         // Matches pix_addr
    logic     active_d2;         // Matches pix_data

    vga_sync_gen sync_i (
        .clk       (clk),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .raw_hsync (raw_hsync),
        .raw_vsync (raw_vsync),
        .active    (active)
    );

    // Last pixel of the 800x525 raster
    assign frame_end = (hcount == hcount_t'(H_TOTAL - 1)) &&
                       (vcount == vcount_t'(V_TOTAL - 1));

    /* Running count of visible pixels gives y*640+x without a multiplier.
       pix_addr holds during blanking, the memory read is simply ignored then */
    always_ff @(posedge clk) begin
        if (rst) begin
            next_addr <= '0;
            pix_addr  <= '0;
        end else if (frame_end) begin
            next_addr <= '0;             // Restart for next frame
        end else if (active) begin
            pix_addr  <= next_addr;
            next_addr <= next_addr + 1'b1;
        end
    end

    // Stage 1 alongside the address register
    always_ff @(posedge clk) begin
        if (rst) begin
            hsync_d1  <= 1'b1;
            vsync_d1  <= 1'b1;
            active_d1 <= 1'b0;
        end else begin
            hsync_d1  <= raw_hsync;
            vsync_d1  <= raw_vsync;
            active_d1 <= active;
        end
    end

    // Stage 2 alongside the memory read
    always_ff @(posedge clk) begin
        if (rst) begin
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            active_d2 <= 1'b0;
        end else begin
            hsync     <= hsync_d1;
            vsync     <= vsync_d1;
            active_d2 <= active_d1;
        end
    end

    // Black outside the visible area
    assign rdata = active_d2 ? pix_data[11:8] : '0;
    assign gdata = active_d2 ? pix_data[7:4]  : '0;
    assign bdata = active_d2 ? pix_data[3:0]  : '0;

    // Address stays inside the frame buffer whenever it is used
    a_addr_range : assert property (
        @(posedge clk) disable iff (rst)
        active_d1 |-> (pix_addr < fb_addr_t'(FB_DEPTH))
    ) else $error("pix_addr %0d beyond frame buffer", pix_addr);

    // Blanking two clocks after the raster leaves the visible area
    a_blank : assert property (
        @(posedge clk) disable iff (rst)
        !active ##2 1'b1 |-> ({rdata, gdata, bdata} == '0)
    ) else $error("colour not blanked");

endmodule

//--- src/vga_sync_gen.sv
/* Free-running 800x525 raster counter with decoded sync and active flags.
   All outputs are registered and aligned to the same counter state. Syncs are active low. */
`timescale 1ns/1ns

module vga_sync_gen import vga_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    output hcount_t hcount,     // Pixel within line
    output vcount_t vcount,     // Line within frame
    output logic    raw_hsync,  // Low during horizontal sync
    output logic    raw_vsync,  // Low during vertical sync
    output logic    active      // Visible area
);

    hcount_t h_next;
    vcount_t v_next;
    logic    line_end;
    logic    frame_end;
    logic    hsync_next;
    logic    vsync_next;
    logic    active_next;

    // Last pixel of a line and of a frame
    assign line_end  = (hcount == hcount_t'(H_TOTAL - 1));
    assign frame_end = line_end && (vcount == vcount_t'(V_TOTAL - 1));

    // Next counter state
    always_comb begin
        if (line_end)
            h_next = '0;
        else
            h_next = hcount + 1'b1;

        // Vertical count only moves at end of line
        if (frame_end)
            v_next = '0;
        else if (line_end)
            v_next = vcount + 1'b1;
        else
            v_next = vcount;
    end

    /* Flags are decoded from the next state so that after the register
       they describe the same pixel as hcount and vcount */
    always_comb begin
        hsync_next  = !((h_next >= hcount_t'(H_SYNC_START)) &&
                        (h_next <  hcount_t'(H_SYNC_END)));     // 656..751 low
        vsync_next  = !((v_next >= vcount_t'(V_SYNC_START)) &&
                        (v_next <  vcount_t'(V_SYNC_END)));     // 490..491 low
        active_next = (h_next < hcount_t'(H_ACTIVE)) &&
                      (v_next < vcount_t'(V_ACTIVE));
    end

    // Counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            hcount <= h_next;
            vcount <= v_next;
        end
    end

    // Registered levels, reset values match pixel 0,0
    always_ff @(posedge clk) begin
        if (rst) begin
            raw_hsync <= 1'b1;       // Not in sync at 0,0
            raw_vsync <= 1'b1;
            active    <= 1'b1;       // 0,0 is visible
        end else begin
            raw_hsync <= hsync_next;
            raw_vsync <= vsync_next;
            active    <= active_next;
        end
    end

    // Counters never leave the raster
    a_hcount_range : assert property (
        @(posedge clk) disable iff (rst)
        hcount < hcount_t'(H_TOTAL)
    ) else $error("hcount %0d out of range", hcount);

    a_vcount_range : assert property (
        @(posedge clk) disable iff (rst)
        vcount < vcount_t'(V_TOTAL)
    ) else $error("vcount %0d out of range", vcount);

endmodule

//--- verification/tb_vga_controller.sv
/* Testbench for the VGA controller. One clock for bus and display, inputs change on falling edges.
   Bus stimulus ends before frame 2 except traffic aimed at lines far from the scan position. */
`timescale 1ns/1ns

module tb_vga_controller import vga_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 3 * H_TOTAL * V_TOTAL + 2000;  // 1,262,000
    localparam int FIRST_HFALL    = H_SYNC_START + 2;              // Counter reach plus 2 stages
    localparam int PIX_LAG        = H_TOTAL - H_SYNC_START;        // 144, hsync fall to x=0
    localparam int LINE_LAG       = V_TOTAL - V_SYNC_START;        // 35 hsync falls to line 0

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      sel;
    fb_addr_t  addr;
    chan_we_t  we;
    bus_word_t qin;
    bus_word_t qout;
    logic      hsync;
    logic      vsync;
    colour_t   rdata;
    colour_t   gdata;
    colour_t   bdata;

    pixel_t    shadow [fb_addr_t];   // Mirror of every in-range bus write
    fb_addr_t  known [$];            // Addresses with fully known contents

    logic      rd_issue = 1'b0;      // Read driven this cycle
    pixel_t    rd_value = '0;        // Its expected word
    logic      rd_chk = 1'b0;
    pixel_t    rd_exp = '0;

    // Raster tracker state
    logic      hs_q;
    logic      vs_q;
    int        rel;                  // Cycles since reset release
    int        h_off;                // Samples since last hsync fall
    int        v_off;
    int        line_cnt;             // hsync falls since last vsync fall
    int        v_falls;
    logic      h_seen = 1'b0;
    logic      v_seen = 1'b0;
    logic      first_chk = 1'b0;
    int        first_val;
    logic      h_per_chk = 1'b0;
    logic      h_low_chk = 1'b0;
    int        h_len;
    logic      v_per_chk = 1'b0;
    logic      v_low_chk = 1'b0;
    int        v_len;
    logic      pix_chk = 1'b0;
    pixel_t    pix_exp;
    pixel_t    pix_got;
    int        pix_checked = 0;
    int        cur_line = -1000;     // Frame 2 line on screen
    logic      sync_done = 1'b0;

    int        cycle = 0;
    int        err_reset = 0;
    int        err_sync = 0;
    int        err_bus = 0;
    int        err_pix = 0;
    int        tests_pass = 0;
    int        tests_fail = 0;

    vga_controller_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .sel   (sel),
        .addr  (addr),
        .we    (we),
        .qin   (qin),
        .qout  (qout),
        .hsync (hsync),
        .vsync (vsync),
        .rdata (rdata),
        .gdata (gdata),
        .bdata (bdata)
    );

    always #20 clk = ~clk;           // 40 ns period

    // Watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, three frames plus 2000, before all tests ended",
                     TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // Expected qout lines up with the cycle after the read
    always @(posedge clk) begin
        rd_chk <= rd_issue && !rst;
        rd_exp <= rd_value;
    end

    /* Measures sync intervals and places each output sample on the raster,
       counting cycles from hsync falls and lines from vsync falls */
    always @(posedge clk) begin : raster_track
        logic     h_fall;
        logic     h_rise;
        logic     v_fall;
        logic     v_rise;
        int       off_now;
        int       lines_now;
        int       v_now;
        int       x;
        int       y;
        fb_addr_t pa;
        if (rst) begin
            hs_q     <= 1'b1;
            vs_q     <= 1'b1;
            rel      <= 0;
            h_off    <= 0;
            v_off    <= 0;
            line_cnt <= 0;
            v_falls  <= 0;
        end else begin
            h_fall    = hs_q && !hsync;
            h_rise    = !hs_q && hsync;
            v_fall    = vs_q && !vsync;
            v_rise    = !vs_q && vsync;
            off_now   = h_fall ? 0 : h_off + 1;
            lines_now = v_fall ? 0 : line_cnt;
            if (h_fall)
                lines_now = lines_now + 1;
            v_now = v_falls + int'(v_fall);
            hs_q      <= hsync;
            vs_q      <= vsync;
            rel       <= rel + 1;
            h_off     <= off_now;
            v_off     <= v_fall ? 0 : v_off + 1;
            line_cnt  <= lines_now;
            v_falls   <= v_now;
            first_chk <= h_fall && !h_seen;
            first_val <= rel;                    // Index of the first low sample
            h_per_chk <= h_fall && h_seen;
            h_low_chk <= h_rise && h_seen;
            h_len     <= h_off + 1;
            v_per_chk <= v_fall && v_seen;
            v_low_chk <= v_rise && v_seen;
            v_len     <= v_off + 1;
            if (h_fall)
                h_seen <= 1'b1;
            if (v_fall)
                v_seen <= 1'b1;
            if (v_rise && v_falls >= 2)
                sync_done <= 1'b1;               // Full vsync period and pulse seen

            x = off_now - PIX_LAG;
            y = lines_now - LINE_LAG;
            pix_got <= {rdata, gdata, bdata};
            pix_chk <= 1'b0;
            pix_exp <= '0;
            if (v_now == 1) begin                // Frame 2 only
                cur_line <= y;
                if (x >= 0 && x < H_ACTIVE && y >= 0 && y < V_ACTIVE) begin
                    pa = fb_addr_t'(y * H_ACTIVE + x);
                    if (shadow.exists(pa)) begin
                        pix_chk     <= 1'b1;
                        pix_exp     <= shadow[pa];
                        pix_checked <= pix_checked + 1;
                    end
                end else begin
                    pix_chk <= 1'b1;             // Blanking must be black
                end
            end
        end
    end

    a_reset_state : assert property (@(posedge clk)
        (cycle >= 1 && ($past(rst) || $past(rst, 2))) |->
        (hsync && vsync && {rdata, gdata, bdata} == '0 && qout == '0))
    else begin
        err_reset++;
        $display("Fail %0t reset outputs: expected hsync=1 vsync=1 rgb=000 qout=0,",
                 $time, " got hsync=%b vsync=%b rgb=%h qout=%h", $sampled(hsync),
                 $sampled(vsync), $sampled({rdata, gdata, bdata}), $sampled(qout));
    end

    a_first_hfall : assert property (@(posedge clk) first_chk |-> first_val == FIRST_HFALL)
    else begin
        err_sync++;
        $display("Fail %0t hsync first fall: expected cycle %0d got %0d",
                 $time, FIRST_HFALL, $sampled(first_val));
    end

    a_h_period : assert property (@(posedge clk) h_per_chk |-> h_len == H_TOTAL)
    else begin
        err_sync++;
        $display("Fail %0t hsync period: expected %0d got %0d", $time, H_TOTAL, $sampled(h_len));
    end

    a_h_low : assert property (@(posedge clk) h_low_chk |-> h_len == H_SYNC)
    else begin
        err_sync++;
        $display("Fail %0t hsync low: expected %0d got %0d", $time, H_SYNC, $sampled(h_len));
    end

    a_v_period : assert property (@(posedge clk) v_per_chk |-> v_len == H_TOTAL * V_TOTAL)
    else begin
        err_sync++;
        $display("Fail %0t vsync period: expected %0d got %0d",
                 $time, H_TOTAL * V_TOTAL, $sampled(v_len));
    end

    a_v_low : assert property (@(posedge clk) v_low_chk |-> v_len == H_TOTAL * V_SYNC)
    else begin
        err_sync++;
        $display("Fail %0t vsync low: expected %0d got %0d",
                 $time, H_TOTAL * V_SYNC, $sampled(v_len));
    end

    // Also covers the zero upper bits
    a_qout : assert property (@(posedge clk) rd_chk |-> qout == bus_word_t'(rd_exp))
    else begin
        err_bus++;
        $display("Fail %0t qout: expected %h got %h",
                 $time, bus_word_t'($sampled(rd_exp)), $sampled(qout));
    end

    a_pixel : assert property (@(posedge clk) pix_chk |-> pix_got == pix_exp)
    else begin
        err_pix++;
        $display("Fail %0t rgb: expected %h got %h", $time, $sampled(pix_exp), $sampled(pix_got));
    end

    // Channel-masked update, bit 2 red down to bit 0 blue
    function automatic pixel_t merge_channels(input pixel_t old, input pixel_t d,
                                              input chan_we_t m);
        pixel_t r;
        r = old;
        if (m[2])
            r[11:8] = d[11:8];
        if (m[1])
            r[7:4] = d[7:4];
        if (m[0])
            r[3:0] = d[3:0];
        return r;
    endfunction

    // Folds all 19 address bits into one pixel
    function automatic pixel_t pattern_of(input fb_addr_t a);
        return a[11:0] ^ {a[18:12], a[18:14]};
    endfunction

    task automatic bus_write(input fb_addr_t a, input chan_we_t m, input pixel_t d);
        @(negedge clk);
        sel      = 1'b1;
        addr     = a;
        we       = m;
        qin      = bus_word_t'($urandom());     // Upper bits must be ignored
        qin[11:0] = d;
        rd_issue = 1'b0;
        if (a < FB_DEPTH)
            shadow[a] = merge_channels(shadow.exists(a) ? shadow[a] : '0, d, m);
    endtask

    task automatic bus_read(input fb_addr_t a);
        @(negedge clk);
        sel      = 1'b1;
        addr     = a;
        we       = '0;
        qin      = '0;
        rd_issue = (a >= FB_DEPTH) || shadow.exists(a);
        rd_value = (a < FB_DEPTH && shadow.exists(a)) ? shadow[a] : '0;
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            sel      = 1'b0;
            we       = '0;
            rd_issue = 1'b0;
        end
    endtask

    // New words get all channels so the mirror never holds unknown nibbles
    task automatic write_random(input fb_addr_t a);
        chan_we_t m;
        m = shadow.exists(a) ? chan_we_t'($urandom_range(7, 1)) : 3'b111;
        bus_write(a, m, pixel_t'($urandom()));
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_pass++;
            $display("Test %s: pass", name);
        end else begin
            tests_fail++;
            $display("Test %s: FAILED, %0d errors", name, errs);
        end
    endtask

    initial begin : main
        int       seed;
        int       err_mark;
        fb_addr_t a;
        fb_addr_t oob [$];
        int       pat_rows [5];
        seed     = $urandom(97271);
        pat_rows = '{0, 1, 2, 3, V_ACTIVE - 1};
        rst  = 1'b1;
        sel  = 1'b0;
        addr = '0;
        we   = '0;
        qin  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        bus_idle(4);
        report_test("1 reset state", err_reset);

        // Fresh words first, then a masked pass over the same words
        err_mark = err_bus;
        repeat (48) begin
            a = fb_addr_t'($urandom_range(FB_DEPTH - 1, 0));
            if (!shadow.exists(a))
                known.push_back(a);
            write_random(a);
        end
        foreach (known[i])
            write_random(known[i]);
        foreach (known[i])
            bus_read(known[i]);
        bus_idle(3);
        report_test("3 bus read-back with channel masks", err_bus - err_mark);

        err_mark = err_bus;
        oob.push_back(fb_addr_t'(FB_DEPTH));
        oob.push_back('1);
        repeat (14)
            oob.push_back(fb_addr_t'($urandom_range(19'h7FFFF, FB_DEPTH)));
        foreach (oob[i])
            bus_write(oob[i], chan_we_t'($urandom_range(7, 1)), pixel_t'($urandom()));
        foreach (oob[i])
            bus_read(oob[i]);
        foreach (known[i])
            bus_read(known[i]);                  // Nothing aliased into the array
        bus_idle(3);
        report_test("4 out-of-range addresses", err_bus - err_mark);

        // Pattern for lines 0 to 3 and 479, long before frame 2
        foreach (pat_rows[r])
            for (int x = 0; x < H_ACTIVE; x++) begin
                a = fb_addr_t'(pat_rows[r] * H_ACTIVE + x);
                bus_write(a, 3'b111, pattern_of(a));
            end
        bus_idle(1);

        // Traffic while frame 2 shows line 1, aimed at lines 240 to 478
        wait (cur_line >= 1);
        err_mark = err_bus;
        repeat (300) begin
            if ($urandom_range(1, 0) == 1) begin
                a = fb_addr_t'($urandom_range(478, 240) * H_ACTIVE +
                               $urandom_range(H_ACTIVE - 1, 0));
                if (!shadow.exists(a))
                    known.push_back(a);
                write_random(a);
            end else begin
                bus_read(known[$urandom_range(known.size() - 1, 0)]);
            end
        end
        bus_idle(3);
        report_test("6 bus traffic during scan-out", err_bus - err_mark);

        // Frame 2 pixel and blanking checks stop at its vsync fall
        wait (sync_done);
        repeat (2) @(posedge clk);
        if (pix_checked < 5 * H_ACTIVE) begin
            $display("Only %0d written pixels were seen on screen in frame 2, expected %0d",
                     pix_checked, 5 * H_ACTIVE);
            err_pix++;
        end
        report_test("5 displayed pixels", err_pix);

        if (!h_seen) begin
            $display("No hsync falling edge was ever seen");
            err_sync++;
        end
        report_test("2 sync timing", err_sync);

        $display("Tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
        if (tests_fail == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
